/* hw/proc_ci_pkg.sv */
package proc_ci_pkg;

    localparam int NUM_REGS = 16;

    // Wishbone-style request, one per master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;   // Word address
        logic [31:0] wdata;
    } wb_req_t;

    typedef struct packed {
        logic        ack;    // High for exactly one cycle
        logic [31:0] rdata;
    } wb_rsp_t;

    // Unlisted codes execute as no-ops
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7,
        OP_BEQ  = 4'h8,
        OP_HALT = 4'hF
    } opcode_e;

    typedef struct packed {
        opcode_e     op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] unused;
    } instr_reg_t;

    typedef struct packed {
        opcode_e            op;
        logic [3:0]         rd;
        logic [3:0]         rs1;
        logic [3:0]         unused;
        logic signed [15:0] imm;
    } instr_imm_t;

    // Same word seen as register form or immediate form
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

/* hw/tiny_core.sv */
`timescale 1ns/100ps

module tiny_core (
    input  logic                 sys_clk,
    input  logic                 rst_n_i,
    output proc_ci_pkg::wb_req_t ibus_req_o,
    input  proc_ci_pkg::wb_rsp_t ibus_rsp_i,
    output proc_ci_pkg::wb_req_t dbus_req_o,
    input  proc_ci_pkg::wb_rsp_t dbus_rsp_i,
    output logic                 halted_o
);
    import proc_ci_pkg::*;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e      state_q;
    logic [31:0] pc_q;                // Word pc
    logic [31:0] rf_q [NUM_REGS];
    instr_u      instr_q;
    wb_req_t     ibus_q;
    wb_req_t     dbus_q;

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] rd_val;
    logic [31:0] imm_ext;
    logic [31:0] pc_inc;
    logic [31:0] pc_next;
    logic [31:0] eff_addr;
    logic [31:0] alu_res;
    logic        alu_wr;

    function automatic wb_req_t fetch_req(input logic [31:0] addr);
        fetch_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: addr, wdata: 32'd0};
    endfunction

    // r0 reads zero
    assign rs1_val = (instr_q.r.rs1 == 4'd0) ? 32'd0 : rf_q[instr_q.r.rs1];
    assign rs2_val = (instr_q.r.rs2 == 4'd0) ? 32'd0 : rf_q[instr_q.r.rs2];
    assign rd_val  = (instr_q.r.rd == 4'd0) ? 32'd0 : rf_q[instr_q.r.rd];

    assign imm_ext  = {{16{instr_q.i.imm[15]}}, instr_q.i.imm};
    assign pc_inc   = pc_q + 32'd1;
    assign eff_addr = rs1_val + imm_ext;

    // Branch is relative to the next instruction
    assign pc_next = (instr_q.r.op == OP_BEQ && rd_val == rs1_val) ? pc_inc + imm_ext : pc_inc;

    always_comb begin
        alu_res = 32'd0;
        alu_wr  = 1'b1;
        case (instr_q.r.op)
            OP_ADD:  alu_res = rs1_val + rs2_val;
            OP_SUB:  alu_res = rs1_val - rs2_val;
            OP_AND:  alu_res = rs1_val & rs2_val;
            OP_OR:   alu_res = rs1_val | rs2_val;
            OP_XOR:  alu_res = rs1_val ^ rs2_val;
            OP_ADDI: alu_res = eff_addr;  // Same adder as the address path
            default: alu_wr  = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            state_q <= S_FETCH;
            pc_q    <= 32'd0;
            instr_q <= '0;
            ibus_q  <= '0;
            dbus_q  <= '0;
            for (int k = 0; k < NUM_REGS; k++) begin
                rf_q[k] <= 32'd0;
            end
        end else begin
            case (state_q)
                S_FETCH: begin
                    if (ibus_rsp_i.ack) begin
                        instr_q <= instr_u'(ibus_rsp_i.rdata);
                        ibus_q  <= '0;
                        state_q <= S_EXEC;
                    end else begin
                        ibus_q <= fetch_req(pc_q);  // First fetch after reset
                    end
                end
                S_EXEC: begin
                    if (alu_wr && instr_q.r.rd != 4'd0) begin
                        rf_q[instr_q.r.rd] <= alu_res;
                    end
                    if (instr_q.r.op == OP_HALT) begin
                        state_q <= S_HALT;
                    end else if (instr_q.r.op == OP_LW || instr_q.r.op == OP_SW) begin
                        pc_q    <= pc_inc;
                        dbus_q  <= '{cyc: 1'b1, stb: 1'b1, we: (instr_q.r.op == OP_SW),
                                     addr: eff_addr, wdata: rd_val};
                        state_q <= S_MEM;
                    end else begin
                        pc_q    <= pc_next;
                        ibus_q  <= fetch_req(pc_next);
                        state_q <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (dbus_rsp_i.ack) begin
                        if (instr_q.r.op == OP_LW && instr_q.r.rd != 4'd0) begin
                            rf_q[instr_q.r.rd] <= dbus_rsp_i.rdata;
                        end
                        dbus_q  <= '0;
                        ibus_q  <= fetch_req(pc_q);  // pc already advanced
                        state_q <= S_FETCH;
                    end
                end
                default: ;  // Halted until reset
            endcase
        end
    end

    assign ibus_req_o = ibus_q;
    assign dbus_req_o = dbus_q;
    assign halted_o   = (state_q == S_HALT);

    // One port at a time, so the arbiter never splits an instruction
    a_ports_exclusive: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(ibus_req_o.cyc && dbus_req_o.cyc));

    a_ibus_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (ibus_req_o.cyc && !ibus_rsp_i.ack) |=> $stable(ibus_req_o));

    a_dbus_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (dbus_req_o.cyc && !dbus_rsp_i.ack) |=> $stable(dbus_req_o));

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                 sys_clk,
    input  logic                 rst_n_i,
    input  proc_ci_pkg::wb_req_t host_req_i,
    input  proc_ci_pkg::wb_req_t data_req_i,
    input  proc_ci_pkg::wb_req_t fetch_req_i,
    output proc_ci_pkg::wb_rsp_t host_rsp_o,
    output proc_ci_pkg::wb_rsp_t data_rsp_o,
    output proc_ci_pkg::wb_rsp_t fetch_rsp_o,
    output proc_ci_pkg::wb_req_t mem_req_o,
    input  proc_ci_pkg::wb_rsp_t mem_rsp_i
);

    logic [2:0] cyc_vec;   // {fetch, data, host}
    logic [2:0] ack_vec;
    logic [2:0] grant_q;
    logic [2:0] grant_d;
    logic       locked;

    assign cyc_vec = {fetch_req_i.cyc, data_req_i.cyc, host_req_i.cyc};
    assign locked  = |(grant_q & cyc_vec);

    always_comb begin
        grant_d = 3'b000;
        if (locked) begin
            grant_d = grant_q;  // Held for the whole cycle
        end else if (mem_rsp_i.ack) begin
            grant_d = 3'b000;   // Owner left early, let its ack drain
        end else if (cyc_vec[0]) begin
            grant_d = 3'b001;
        end else if (cyc_vec[1]) begin
            grant_d = 3'b010;
        end else if (cyc_vec[2]) begin
            grant_d = 3'b100;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            grant_q <= 3'b000;
        end else begin
            grant_q <= grant_d;
        end
    end

    always_comb begin
        mem_req_o = '0;
        case (grant_d)
            3'b001:  mem_req_o = host_req_i;
            3'b010:  mem_req_o = data_req_i;
            3'b100:  mem_req_o = fetch_req_i;
            default: ;
        endcase
    end

    assign host_rsp_o.ack    = mem_rsp_i.ack & grant_d[0];
    assign host_rsp_o.rdata  = mem_rsp_i.rdata;
    assign data_rsp_o.ack    = mem_rsp_i.ack & grant_d[1];
    assign data_rsp_o.rdata  = mem_rsp_i.rdata;
    assign fetch_rsp_o.ack   = mem_rsp_i.ack & grant_d[2];
    assign fetch_rsp_o.rdata = mem_rsp_i.rdata;

    assign ack_vec = {fetch_rsp_o.ack, data_rsp_o.ack, host_rsp_o.ack};

    a_one_grant: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        $onehot0(grant_d));

    // Ack only to a master granted last cycle that still holds cyc
    a_ack_owner: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (ack_vec & ~(grant_q & cyc_vec)) == 3'b000);

endmodule

/* hw/wb_ram.sv */
`timescale 1ns/100ps

module wb_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 sys_clk,
    input  logic                 rst_n_i,
    input  proc_ci_pkg::wb_req_t req_i,
    output proc_ci_pkg::wb_rsp_t rsp_o
);

    logic [31:0] mem_q [MEM_WORDS];
    logic [31:0] word_idx;
    logic [31:0] rdata_q;
    logic        access;
    logic        ack_q;

    assign word_idx = req_i.addr % MEM_WORDS;  // Wraps around
    assign access   = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (req_i.we) begin
                mem_q[word_idx] <= req_i.wdata;
            end
            rdata_q <= mem_q[word_idx];
        end
    end

    // Ack cycle never counts as a new access
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.rdata = rdata_q;

endmodule

/* hw/host_ctrl.sv */
`timescale 1ns/100ps

module host_ctrl #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 sys_clk,
    input  logic                 rst_n_i,
    input  logic                 host_wr_i,
    input  logic                 host_rd_i,
    input  logic [31:0]          host_addr_i,
    input  logic [31:0]          host_wdata_i,
    output logic [31:0]          host_rdata_o,
    output logic                 host_done_o,
    input  logic                 run_i,
    output logic                 core_rst_n_o,
    output proc_ci_pkg::wb_req_t bus_req_o,
    input  proc_ci_pkg::wb_rsp_t bus_rsp_i
);
    import proc_ci_pkg::*;

    wb_req_t     req_q;
    logic [31:0] rdata_q;
    logic        done_q;
    logic        strobe;
    logic        finish;

    assign strobe = host_wr_i || host_rd_i;
    assign finish = req_q.cyc && bus_rsp_i.ack;

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            req_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (finish) begin
                req_q.cyc <= 1'b0;
                req_q.stb <= 1'b0;
                done_q    <= 1'b1;
            end else if (strobe) begin
                req_q <= '{cyc: 1'b1, stb: 1'b1, we: host_wr_i,
                           addr: host_addr_i, wdata: host_wdata_i};
            end
        end
    end

    // Read data held until the next read completes
    always_ff @(posedge sys_clk) begin
        if (finish && !req_q.we) begin
            rdata_q <= bus_rsp_i.rdata;
        end
    end

    assign bus_req_o    = req_q;
    assign host_rdata_o = rdata_q;
    assign host_done_o  = done_q;
    assign core_rst_n_o = rst_n_i & run_i;  // Core runs only when told to

    a_no_overlap: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        strobe |-> !req_q.cyc);

    a_single_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(host_wr_i && host_rd_i));

    a_addr_range: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        strobe |-> host_addr_i < MEM_WORDS);

endmodule

/* hw/processorci_top.sv */
`timescale 1ns/100ps

module processorci_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic        sys_clk,
    input  logic        rst_n_i,
    input  logic        host_wr_i,
    input  logic        host_rd_i,
    input  logic [31:0] host_addr_i,
    input  logic [31:0] host_wdata_i,
    output logic [31:0] host_rdata_o,
    output logic        host_done_o,
    input  logic        run_i,
    output logic        halted_o
);
    import proc_ci_pkg::*;

    wb_req_t host_req;
    wb_rsp_t host_rsp;
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    wb_req_t dbus_req;
    wb_rsp_t dbus_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;
    logic    core_rst_n;    // Held low until run_i

    host_ctrl #(
        .MEM_WORDS    (MEM_WORDS)
    ) u_host_ctrl (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .host_wr_i    (host_wr_i),
        .host_rd_i    (host_rd_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .host_done_o  (host_done_o),
        .run_i        (run_i),
        .core_rst_n_o (core_rst_n),
        .bus_req_o    (host_req),
        .bus_rsp_i    (host_rsp)
    );

    tiny_core u_core (
        .sys_clk    (sys_clk),
        .rst_n_i    (core_rst_n),
        .ibus_req_o (ibus_req),
        .ibus_rsp_i (ibus_rsp),
        .dbus_req_o (dbus_req),
        .dbus_rsp_i (dbus_rsp),
        .halted_o   (halted_o)
    );

    // Host wins over data, data over fetch
    bus_arbiter u_arbiter (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .host_req_i  (host_req),
        .data_req_i  (dbus_req),
        .fetch_req_i (ibus_req),
        .host_rsp_o  (host_rsp),
        .data_rsp_o  (dbus_rsp),
        .fetch_rsp_o (ibus_rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    wb_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .sys_clk   (sys_clk),
        .rst_n_i   (rst_n_i),
        .req_i     (mem_req),
        .rsp_o     (mem_rsp)
    );

endmodule

/* verif/processorci_tb.sv */
`timescale 1ns/100ps

module processorci_tb;
    import proc_ci_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int CLK_PERIOD  = 8;
    localparam int SEED        = 50844;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 20000;   // Generous budget per test
    localparam int STEP_LIMIT  = 5000;    // Instructions the model may run

    logic        clk;
    logic        rst_n;
    logic        host_wr;
    logic        host_rd;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        host_done;
    logic        run;
    logic        halted;

    logic [31:0] mem_model [MEM_WORDS];   // Expected RAM contents
    logic [31:0] prog [$];

    processorci_top #(
        .MEM_WORDS    (MEM_WORDS)
    ) dut_i (
        .sys_clk      (clk),
        .rst_n_i      (rst_n),
        .host_wr_i    (host_wr),
        .host_rd_i    (host_rd),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata),
        .host_done_o  (host_done),
        .run_i        (run),
        .halted_o     (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: run exceeded its cycle budget, halted_o or host_done_o never came");
        end_with_failure();
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            end_with_failure();
        end
    endtask

    // Inputs change 1 ns after the edge, outputs are read there too
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        tick();
        host_addr  = addr;
        host_wdata = data;
        host_wr    = 1'b1;
        tick();
        host_wr = 1'b0;
        while (!host_done) tick();
        mem_model[addr % MEM_WORDS] = data;
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
        tick();
        host_addr = addr;
        host_rd   = 1'b1;
        tick();
        host_rd = 1'b0;
        while (!host_done) tick();
        data = host_rdata;   // Valid with the done pulse
    endtask

    function automatic logic [31:0] reg_instr(input opcode_e op, input int rd,
                                              input int rs1, input int rs2);
        instr_u w;
        w       = '0;
        w.r.op  = op;
        w.r.rd  = rd[3:0];
        w.r.rs1 = rs1[3:0];
        w.r.rs2 = rs2[3:0];
        return w;
    endfunction

    function automatic logic [31:0] imm_instr(input opcode_e op, input int rd,
                                              input int rs1, input int imm);
        instr_u w;
        w       = '0;
        w.i.op  = op;
        w.i.rd  = rd[3:0];
        w.i.rs1 = rs1[3:0];
        w.i.imm = imm[15:0];
        return w;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hA5A5_A5A5;
    endfunction

    task automatic fill_region(input int base, input int count);
        for (int k = 0; k < count; k++) begin
            host_write(base + k, fill_word(base + k));
        end
    endtask

    task automatic load_program();
        for (int k = 0; k < prog.size(); k++) begin
            host_write(k, prog[k]);
        end
    endtask

    // Reference interpreter working on the expected memory image
    task automatic predict_program();
        logic [31:0] regs [NUM_REGS];
        instr_u      w;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] imm;
        int          steps;
        bit          done;
        for (int k = 0; k < NUM_REGS; k++) regs[k] = 32'd0;
        pc    = 32'd0;
        steps = 0;
        done  = 1'b0;
        while (!done) begin
            if (steps == STEP_LIMIT) begin
                $display("Reference model ran %0d steps without reaching HALT", steps);
                end_with_failure();
            end
            w   = mem_model[pc % MEM_WORDS];
            a   = regs[w.r.rs1];
            b   = regs[w.r.rs2];
            d   = regs[w.r.rd];
            imm = $signed(w.i.imm);
            pc  = pc + 1;
            case (w.r.op)
                OP_ADD:  regs[w.r.rd] = a + b;
                OP_SUB:  regs[w.r.rd] = a - b;
                OP_AND:  regs[w.r.rd] = a & b;
                OP_OR:   regs[w.r.rd] = a | b;
                OP_XOR:  regs[w.r.rd] = a ^ b;
                OP_ADDI: regs[w.r.rd] = a + imm;
                OP_LW:   regs[w.r.rd] = mem_model[(a + imm) % MEM_WORDS];
                OP_SW:   mem_model[(a + imm) % MEM_WORDS] = d;
                OP_BEQ:  if (d == a) pc = pc + imm;   // Relative to next
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            regs[0] = 32'd0;   // r0 stays zero
            steps++;
        end
    endtask

    task automatic start_and_wait_halt();
        tick();
        run = 1'b1;
        while (!halted) tick();
    endtask

    task automatic stop_core();
        tick();
        run = 1'b0;
        repeat (2) tick();
        check_word("halted_o", {31'd0, halted}, 32'd0);
    endtask

    task automatic check_results(input int base, input int count);
        logic [31:0] got;
        for (int k = 0; k < count; k++) begin
            host_read(base + k, got);
            check_word($sformatf("host_rdata_o @0x%02h", base + k), got,
                       mem_model[base + k]);
        end
    endtask

    task automatic test_reset();
        repeat (5) begin
            tick();
            check_word("host_done_o", {31'd0, host_done}, 32'd0);
            check_word("halted_o", {31'd0, halted}, 32'd0);
        end
        rst_n = 1'b1;
        repeat (10) begin
            tick();
            check_word("host_done_o", {31'd0, host_done}, 32'd0);
            check_word("halted_o", {31'd0, halted}, 32'd0);
        end
    endtask

    task automatic test_host_memory();
        logic [31:0] addrs [16];
        logic [31:0] got;
        for (int k = 0; k < 16; k++) begin
            addrs[k] = $urandom % MEM_WORDS;
            host_write(addrs[k], $urandom);
        end
        for (int k = 0; k < 16; k++) begin
            host_read(addrs[k], got);
            check_word($sformatf("host_rdata_o @0x%02h", addrs[k]), got,
                       mem_model[addrs[k]]);
        end
        check_word("halted_o", {31'd0, halted}, 32'd0);
    endtask

    task automatic test_alu();
        logic [31:0] got;
        int          a;
        int          b;
        a = $urandom % 65536;
        b = $urandom % 65536;
        prog.delete();
        prog.push_back(imm_instr(OP_ADDI, 1, 0, a));
        prog.push_back(imm_instr(OP_ADDI, 2, 0, b));
        prog.push_back(reg_instr(OP_ADD, 3, 1, 2));
        prog.push_back(reg_instr(OP_SUB, 4, 1, 2));
        prog.push_back(reg_instr(OP_AND, 5, 1, 2));
        prog.push_back(reg_instr(OP_OR, 6, 1, 2));
        prog.push_back(reg_instr(OP_XOR, 7, 1, 2));
        prog.push_back(imm_instr(OP_ADDI, 0, 1, 5));   // Writes to r0 are lost
        prog.push_back(reg_instr(OP_ADD, 0, 1, 2));
        for (int k = 0; k < 5; k++) begin
            prog.push_back(imm_instr(OP_SW, 3 + k, 0, 'h80 + k));
        end
        prog.push_back(imm_instr(OP_SW, 0, 0, 'h85));
        prog.push_back(imm_instr(OP_HALT, 0, 0, 0));
        fill_region('h80, 6);
        load_program();
        predict_program();
        start_and_wait_halt();
        check_results('h80, 6);
        host_read('h85, got);
        check_word("host_rdata_o @0x85 (r0)", got, 32'd0);
        stop_core();
    endtask

    task automatic test_imm_load();
        logic [31:0] got;
        for (int k = 0; k < 4; k++) host_write('hA0 + k, $urandom);
        prog.delete();
        prog.push_back(imm_instr(OP_ADDI, 1, 0, 'hA0));
        prog.push_back(imm_instr(OP_ADDI, 2, 0, -5));
        prog.push_back(imm_instr(OP_ADDI, 3, 0, -32768));
        for (int k = 0; k < 4; k++) prog.push_back(imm_instr(OP_LW, 4 + k, 1, k));
        prog.push_back(reg_instr(OP_ADD, 8, 4, 2));
        prog.push_back(imm_instr(OP_ADDI, 9, 5, -1));
        for (int k = 0; k < 4; k++) prog.push_back(imm_instr(OP_SW, 4 + k, 1, 16 + k));
        prog.push_back(imm_instr(OP_SW, 2, 1, 20));
        prog.push_back(imm_instr(OP_SW, 3, 1, 21));
        prog.push_back(imm_instr(OP_SW, 8, 1, 22));
        prog.push_back(imm_instr(OP_SW, 9, 1, 23));
        prog.push_back(imm_instr(OP_ADDI, 10, 0, 'hC0));
        prog.push_back(imm_instr(OP_SW, 8, 10, -8));   // Negative offset to 0xB8
        prog.push_back(imm_instr(OP_HALT, 0, 0, 0));
        fill_region('hB0, 9);
        load_program();
        predict_program();
        start_and_wait_halt();
        check_results('hB0, 9);
        host_read('hB4, got);
        check_word("host_rdata_o @0xB4 (imm -5)", got, 32'hFFFF_FFFB);
        stop_core();
    endtask

    task automatic test_branch_rerun();
        for (int k = 0; k < 8; k++) host_write('hC0 + k, $urandom);
        prog.delete();
        prog.push_back(imm_instr(OP_ADDI, 1, 0, 'hC0));   // Array pointer
        prog.push_back(imm_instr(OP_ADDI, 2, 0, 8));      // Countdown
        prog.push_back(imm_instr(OP_ADDI, 3, 0, 0));
        prog.push_back(imm_instr(OP_BEQ, 2, 0, 5));       // Done, go to 9
        prog.push_back(imm_instr(OP_LW, 4, 1, 0));
        prog.push_back(reg_instr(OP_ADD, 3, 3, 4));
        prog.push_back(imm_instr(OP_ADDI, 1, 1, 1));
        prog.push_back(imm_instr(OP_ADDI, 2, 2, -1));
        prog.push_back(imm_instr(OP_BEQ, 0, 0, -6));      // Back to 3
        prog.push_back(imm_instr(OP_SW, 3, 0, 'hD0));
        prog.push_back(imm_instr(OP_HALT, 0, 0, 0));
        fill_region('hD0, 1);
        load_program();
        predict_program();
        start_and_wait_halt();
        check_results('hD0, 1);
        stop_core();
        // Second run from pc zero must store the sum again
        fill_region('hD0, 1);
        predict_program();
        start_and_wait_halt();
        check_results('hD0, 1);
        stop_core();
    endtask

    task automatic test_contention();
        logic [31:0] got;
        logic [31:0] addr;
        prog.delete();
        prog.push_back(imm_instr(OP_ADDI, 2, 0, 150));
        prog.push_back(imm_instr(OP_ADDI, 3, 0, 0));
        prog.push_back(reg_instr(OP_ADD, 3, 3, 2));
        prog.push_back(imm_instr(OP_LW, 4, 0, 'hC0));
        prog.push_back(reg_instr(OP_ADD, 5, 5, 4));
        prog.push_back(imm_instr(OP_ADDI, 2, 2, -1));
        prog.push_back(imm_instr(OP_BEQ, 2, 0, 1));       // Exit to 8
        prog.push_back(imm_instr(OP_BEQ, 0, 0, -6));      // Loop to 2
        prog.push_back(imm_instr(OP_SW, 3, 0, 'hD1));
        prog.push_back(imm_instr(OP_SW, 5, 0, 'hD2));
        prog.push_back(imm_instr(OP_HALT, 0, 0, 0));
        fill_region('hD1, 2);
        load_program();
        predict_program();
        tick();
        run = 1'b1;
        for (int k = 0; k < 20; k++) begin
            addr = 'hE0 + (k % 32);
            host_write(addr, $urandom);
            host_read(addr, got);
            check_word($sformatf("host_rdata_o @0x%02h", addr), got, mem_model[addr]);
        end
        check_word("halted_o during host traffic", {31'd0, halted}, 32'd0);
        while (!halted) tick();
        check_results('hD1, 2);
        stop_core();
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = 32'd0;
        host_wdata = 32'd0;
        run        = 1'b0;
        void'($urandom(SEED));
        test_reset();
        test_host_memory();
        test_alu();
        test_imm_load();
        test_branch_rerun();
        test_contention();
        $display("All checks passed");
        $finish;
    end

endmodule

/* list.f */
hw/proc_ci_pkg.sv
hw/tiny_core.sv
hw/bus_arbiter.sv
hw/wb_ram.sv
hw/host_ctrl.sv
hw/processorci_top.sv
verif/processorci_tb.sv
